/* include/udp_echo_defines.svh */
// Header sizes, IPv4 constants and the default echo port
`ifndef UDP_ECHO_DEFINES_SVH
`define UDP_ECHO_DEFINES_SVH

// Default UDP echo service port
`define ECHO_UDP_PORT 16'd7

// Header lengths in bytes, no IP options
`define IP_HDR_BYTES 20
`define UDP_HDR_BYTES 8

// Version 4 with a five-word header
`define IP_VER_IHL 8'h45

// Protocol field value for UDP
`define IP_PROTO_UDP 8'd17

// TTL placed in every reply
`define IP_DEFAULT_TTL 8'd64

`endif

/* verilog/udp_echo_pkg.sv */
// Width typedefs and state machine enums for the UDP echo path
package udp_echo_pkg;

    // One byte of a stream
    typedef logic [7:0] byte_t;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // UDP port number
    typedef logic [15:0] udp_port_t;

    // UDP length, counts the 8-byte UDP header too
    typedef logic [15:0] udp_len_t;

    // Receive parser
    typedef enum logic [1:0] {
        RX_HDR,
        RX_WAIT_HDR,
        RX_PAYLOAD,
        RX_DROP
    } rx_state_t;

    // Transmit framer
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HDR,
        TX_PAYLOAD
    } tx_state_t;

endpackage

/* verilog/ip_udp_rx_parser.sv */
// IPv4/UDP receive parser: header capture, header checks and payload pass-through
`include "udp_echo_defines.svh"

module ip_udp_rx_parser (
    input  logic                  clk,
    input  logic                  reset,

    input  udp_echo_pkg::byte_t   in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  in_last,
    input  logic                  in_user,

    output logic                  hdr_valid,
    input  logic                  hdr_ready,
    output udp_echo_pkg::ip_addr_t  ip_source_ip,
    output udp_echo_pkg::ip_addr_t  ip_dest_ip,
    output udp_echo_pkg::udp_port_t source_port,
    output udp_echo_pkg::udp_port_t dest_port,
    output udp_echo_pkg::udp_len_t  length,

    output udp_echo_pkg::byte_t   pay_data,
    output logic                  pay_valid,
    input  logic                  pay_ready,
    output logic                  pay_last,
    output logic                  pay_user
);
    import udp_echo_pkg::*;

    localparam logic [4:0] HDR_LAST = 5'(`IP_HDR_BYTES + `UDP_HDR_BYTES - 1);

    rx_state_t  state;
    logic [4:0] hdr_cnt;
    logic       hdr_bad;

    // Only version 4, IHL 5 and protocol UDP get through
    assign hdr_bad = ((hdr_cnt == 5'd0) && (in_data != `IP_VER_IHL)) ||
                     ((hdr_cnt == 5'd9) && (in_data != `IP_PROTO_UDP));

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= RX_HDR;
            hdr_cnt <= '0;
        end else begin
            case (state)
                RX_HDR: begin
                    if (in_valid) begin
                        if (in_last) begin
                            // Runt packet, already fully consumed
                            hdr_cnt <= '0;
                        end else if (hdr_bad) begin
                            hdr_cnt <= '0;
                            state   <= RX_DROP;
                        end else if (hdr_cnt == HDR_LAST) begin
                            hdr_cnt <= '0;
                            state   <= RX_WAIT_HDR;
                        end else begin
                            hdr_cnt <= hdr_cnt + 5'd1;
                        end
                    end
                end
                RX_WAIT_HDR: begin
                    if (hdr_ready) begin
                        state <= RX_PAYLOAD;
                    end
                end
                RX_PAYLOAD: begin
                    if (in_valid && pay_ready && in_last) begin
                        state <= RX_HDR;
                    end
                end
                RX_DROP: begin
                    if (in_valid && in_last) begin
                        state <= RX_HDR;
                    end
                end
                default: state <= RX_HDR;
            endcase
        end
    end

    // Field capture, network byte order
    always_ff @(posedge clk) begin
        if ((state == RX_HDR) && in_valid) begin
            case (hdr_cnt)
                5'd12: ip_source_ip[31:24] <= in_data;
                5'd13: ip_source_ip[23:16] <= in_data;
                5'd14: ip_source_ip[15:8]  <= in_data;
                5'd15: ip_source_ip[7:0]   <= in_data;
                5'd16: ip_dest_ip[31:24]   <= in_data;
                5'd17: ip_dest_ip[23:16]   <= in_data;
                5'd18: ip_dest_ip[15:8]    <= in_data;
                5'd19: ip_dest_ip[7:0]     <= in_data;
                5'd20: source_port[15:8]   <= in_data;
                5'd21: source_port[7:0]    <= in_data;
                5'd22: dest_port[15:8]     <= in_data;
                5'd23: dest_port[7:0]      <= in_data;
                5'd24: length[15:8]        <= in_data;
                5'd25: length[7:0]         <= in_data;
                default: ;
            endcase
        end
    end

    assign hdr_valid = (state == RX_WAIT_HDR);

    always_comb begin
        in_ready  = 1'b0;
        pay_valid = 1'b0;
        case (state)
            RX_HDR, RX_DROP: in_ready = 1'b1;
            RX_PAYLOAD: begin
                in_ready  = pay_ready;
                pay_valid = in_valid;
            end
            default: ;
        endcase
    end

    // Payload goes straight through
    assign pay_data = in_data;
    assign pay_last = in_last;
    assign pay_user = in_user;

endmodule

/* verilog/udp_loopback.sv */
// UDP echo: port match, address and port swap, payload forward or drop
`include "udp_echo_defines.svh"

module udp_loopback #(
    parameter udp_echo_pkg::udp_port_t UDP_PORT = `ECHO_UDP_PORT
) (
    input  logic                    clk,
    input  logic                    reset,

    input  udp_echo_pkg::ip_addr_t  local_ip,

    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  rx_ip_source_ip,
    input  udp_echo_pkg::udp_port_t rx_source_port,
    input  udp_echo_pkg::udp_port_t rx_dest_port,
    input  udp_echo_pkg::udp_len_t  rx_length,

    input  udp_echo_pkg::byte_t     rx_pay_data,
    input  logic                    rx_pay_valid,
    output logic                    rx_pay_ready,
    input  logic                    rx_pay_last,
    input  logic                    rx_pay_user,

    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t  tx_ip_source_ip,
    output udp_echo_pkg::ip_addr_t  tx_ip_dest_ip,
    output udp_echo_pkg::byte_t     tx_ip_ttl,
    output udp_echo_pkg::udp_port_t tx_source_port,
    output udp_echo_pkg::udp_port_t tx_dest_port,
    output udp_echo_pkg::udp_len_t  tx_length,

    output udp_echo_pkg::byte_t     tx_pay_data,
    output logic                    tx_pay_valid,
    input  logic                    tx_pay_ready,
    output logic                    tx_pay_last,
    output logic                    tx_pay_user
);
    logic match;
    logic fwd_pkt;
    logic drop_pkt;

    // Header fields stay put in the parser until the payload is done
    assign match = (rx_dest_port == UDP_PORT);

    always_ff @(posedge clk) begin
        if (reset) begin
            fwd_pkt  <= 1'b0;
            drop_pkt <= 1'b0;
        end else if (rx_pay_valid && rx_pay_ready && rx_pay_last) begin
            fwd_pkt  <= 1'b0;
            drop_pkt <= 1'b0;
        end else if (rx_pay_valid && !fwd_pkt && !drop_pkt) begin
            fwd_pkt  <= match;
            drop_pkt <= !match;
        end
    end

    // Non-matching headers are swallowed immediately
    assign tx_hdr_valid    = rx_hdr_valid && match;
    assign rx_hdr_ready    = (tx_hdr_ready && match) || !match;
    assign tx_ip_source_ip = local_ip;
    assign tx_ip_dest_ip   = rx_ip_source_ip;
    assign tx_ip_ttl       = `IP_DEFAULT_TTL;
    assign tx_source_port  = rx_dest_port;
    assign tx_dest_port    = rx_source_port;
    assign tx_length       = rx_length;

    assign tx_pay_data  = rx_pay_data;
    assign tx_pay_valid = rx_pay_valid && fwd_pkt;
    assign rx_pay_ready = (tx_pay_ready && fwd_pkt) || drop_pkt;
    assign tx_pay_last  = rx_pay_last;
    assign tx_pay_user  = rx_pay_user;

endmodule

/* verilog/ip_udp_tx_framer.sv */
// IPv4/UDP transmit framer: header byte generation, IP checksum and payload append
`include "udp_echo_defines.svh"

module ip_udp_tx_framer (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    hdr_valid,
    output logic                    hdr_ready,
    input  udp_echo_pkg::ip_addr_t  ip_source_ip,
    input  udp_echo_pkg::ip_addr_t  ip_dest_ip,
    input  udp_echo_pkg::byte_t     ip_ttl,
    input  udp_echo_pkg::udp_port_t source_port,
    input  udp_echo_pkg::udp_port_t dest_port,
    input  udp_echo_pkg::udp_len_t  length,

    input  udp_echo_pkg::byte_t     pay_data,
    input  logic                    pay_valid,
    output logic                    pay_ready,
    input  logic                    pay_last,
    input  logic                    pay_user,

    output udp_echo_pkg::byte_t     out_data,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    out_last,
    output logic                    out_user
);
    import udp_echo_pkg::*;

    localparam logic [4:0] HDR_LAST = 5'(`IP_HDR_BYTES + `UDP_HDR_BYTES - 1);

    tx_state_t  state;
    logic [4:0] hdr_idx;
    byte_t      hdr_byte;
    udp_len_t   total_len;

    ip_addr_t   src_ip_r;
    ip_addr_t   dst_ip_r;
    byte_t      ttl_r;
    udp_port_t  src_port_r;
    udp_port_t  dst_port_r;
    udp_len_t   udp_len_r;
    udp_len_t   total_len_r;
    logic [15:0] ip_csum_r;

    // Ones'-complement sum over the ten header words, checksum word as zero
    function automatic logic [15:0] ip_checksum(
        input ip_addr_t src,
        input ip_addr_t dst,
        input byte_t    ttl,
        input udp_len_t tot_len
    );
        logic [31:0] sum;
        sum = {16'h0, `IP_VER_IHL, 8'h00} + {16'h0, tot_len} + {16'h0, ttl, `IP_PROTO_UDP};
        sum = sum + {16'h0, src[31:16]} + {16'h0, src[15:0]};
        sum = sum + {16'h0, dst[31:16]} + {16'h0, dst[15:0]};
        // Two folds absorb every carry
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        return ~sum[15:0];
    endfunction

    assign total_len = length + 16'(`IP_HDR_BYTES);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            hdr_idx <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (hdr_valid) begin
                        hdr_idx <= '0;
                        state   <= TX_HDR;
                    end
                end
                TX_HDR: begin
                    if (out_ready) begin
                        if (hdr_idx == HDR_LAST) begin
                            state <= TX_PAYLOAD;
                        end else begin
                            hdr_idx <= hdr_idx + 5'd1;
                        end
                    end
                end
                TX_PAYLOAD: begin
                    if (pay_valid && out_ready && pay_last) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_valid && hdr_ready) begin
            src_ip_r    <= ip_source_ip;
            dst_ip_r    <= ip_dest_ip;
            ttl_r       <= ip_ttl;
            src_port_r  <= source_port;
            dst_port_r  <= dest_port;
            udp_len_r   <= length;
            total_len_r <= total_len;
            ip_csum_r   <= ip_checksum(ip_source_ip, ip_dest_ip, ip_ttl, total_len);
        end
    end

    // IPv4 header then UDP header, UDP checksum left at zero
    always_comb begin
        case (hdr_idx)
            5'd0:  hdr_byte = `IP_VER_IHL;
            5'd2:  hdr_byte = total_len_r[15:8];
            5'd3:  hdr_byte = total_len_r[7:0];
            5'd8:  hdr_byte = ttl_r;
            5'd9:  hdr_byte = `IP_PROTO_UDP;
            5'd10: hdr_byte = ip_csum_r[15:8];
            5'd11: hdr_byte = ip_csum_r[7:0];
            5'd12: hdr_byte = src_ip_r[31:24];
            5'd13: hdr_byte = src_ip_r[23:16];
            5'd14: hdr_byte = src_ip_r[15:8];
            5'd15: hdr_byte = src_ip_r[7:0];
            5'd16: hdr_byte = dst_ip_r[31:24];
            5'd17: hdr_byte = dst_ip_r[23:16];
            5'd18: hdr_byte = dst_ip_r[15:8];
            5'd19: hdr_byte = dst_ip_r[7:0];
            5'd20: hdr_byte = src_port_r[15:8];
            5'd21: hdr_byte = src_port_r[7:0];
            5'd22: hdr_byte = dst_port_r[15:8];
            5'd23: hdr_byte = dst_port_r[7:0];
            5'd24: hdr_byte = udp_len_r[15:8];
            5'd25: hdr_byte = udp_len_r[7:0];
            default: hdr_byte = 8'h00;
        endcase
    end

    assign hdr_ready = (state == TX_IDLE);

    always_comb begin
        out_data  = hdr_byte;
        out_valid = 1'b0;
        out_last  = 1'b0;
        out_user  = 1'b0;
        pay_ready = 1'b0;
        case (state)
            TX_HDR: out_valid = 1'b1;
            TX_PAYLOAD: begin
                out_data  = pay_data;
                out_valid = pay_valid;
                out_last  = pay_last;
                out_user  = pay_user;
                pay_ready = out_ready;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/udp_echo_top.sv */
// UDP echo top level: receive parser, loopback and transmit framer
`include "udp_echo_defines.svh"

module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t UDP_PORT = `ECHO_UDP_PORT
) (
    input  logic                   clk,
    input  logic                   reset,
    input  udp_echo_pkg::ip_addr_t local_ip,

    input  udp_echo_pkg::byte_t    in_data,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic                   in_last,
    input  logic                   in_user,

    output udp_echo_pkg::byte_t    out_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic                   out_last,
    output logic                   out_user
);
    import udp_echo_pkg::*;

    logic      rx_hdr_valid;
    logic      rx_hdr_ready;
    ip_addr_t  rx_ip_source_ip;
    udp_port_t rx_source_port;
    udp_port_t rx_dest_port;
    udp_len_t  rx_length;
    byte_t     rx_pay_data;
    logic      rx_pay_valid;
    logic      rx_pay_ready;
    logic      rx_pay_last;
    logic      rx_pay_user;

    logic      tx_hdr_valid;
    logic      tx_hdr_ready;
    ip_addr_t  tx_ip_source_ip;
    ip_addr_t  tx_ip_dest_ip;
    byte_t     tx_ip_ttl;
    udp_port_t tx_source_port;
    udp_port_t tx_dest_port;
    udp_len_t  tx_length;
    byte_t     tx_pay_data;
    logic      tx_pay_valid;
    logic      tx_pay_ready;
    logic      tx_pay_last;
    logic      tx_pay_user;

    // Received destination address is not needed for the reply
    ip_udp_rx_parser i_ip_udp_rx_parser (
        .clk          (clk),
        .reset        (reset),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_last      (in_last),
        .in_user      (in_user),
        .hdr_valid    (rx_hdr_valid),
        .hdr_ready    (rx_hdr_ready),
        .ip_source_ip (rx_ip_source_ip),
        .ip_dest_ip   (),
        .source_port  (rx_source_port),
        .dest_port    (rx_dest_port),
        .length       (rx_length),
        .pay_data     (rx_pay_data),
        .pay_valid    (rx_pay_valid),
        .pay_ready    (rx_pay_ready),
        .pay_last     (rx_pay_last),
        .pay_user     (rx_pay_user)
    );

    udp_loopback #(
        .UDP_PORT (UDP_PORT)
    ) i_udp_loopback (
        .clk             (clk),
        .reset           (reset),
        .local_ip        (local_ip),
        .rx_hdr_valid    (rx_hdr_valid),
        .rx_hdr_ready    (rx_hdr_ready),
        .rx_ip_source_ip (rx_ip_source_ip),
        .rx_source_port  (rx_source_port),
        .rx_dest_port    (rx_dest_port),
        .rx_length       (rx_length),
        .rx_pay_data     (rx_pay_data),
        .rx_pay_valid    (rx_pay_valid),
        .rx_pay_ready    (rx_pay_ready),
        .rx_pay_last     (rx_pay_last),
        .rx_pay_user     (rx_pay_user),
        .tx_hdr_valid    (tx_hdr_valid),
        .tx_hdr_ready    (tx_hdr_ready),
        .tx_ip_source_ip (tx_ip_source_ip),
        .tx_ip_dest_ip   (tx_ip_dest_ip),
        .tx_ip_ttl       (tx_ip_ttl),
        .tx_source_port  (tx_source_port),
        .tx_dest_port    (tx_dest_port),
        .tx_length       (tx_length),
        .tx_pay_data     (tx_pay_data),
        .tx_pay_valid    (tx_pay_valid),
        .tx_pay_ready    (tx_pay_ready),
        .tx_pay_last     (tx_pay_last),
        .tx_pay_user     (tx_pay_user)
    );

    ip_udp_tx_framer i_ip_udp_tx_framer (
        .clk          (clk),
        .reset        (reset),
        .hdr_valid    (tx_hdr_valid),
        .hdr_ready    (tx_hdr_ready),
        .ip_source_ip (tx_ip_source_ip),
        .ip_dest_ip   (tx_ip_dest_ip),
        .ip_ttl       (tx_ip_ttl),
        .source_port  (tx_source_port),
        .dest_port    (tx_dest_port),
        .length       (tx_length),
        .pay_data     (tx_pay_data),
        .pay_valid    (tx_pay_valid),
        .pay_ready    (tx_pay_ready),
        .pay_last     (tx_pay_last),
        .pay_user     (tx_pay_user),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last),
        .out_user     (out_user)
    );

endmodule

/* verif/udp_echo_tb.sv */
// UDP echo testbench with clock, reset, DUT, packet builder, reference model, checks and tests
module udp_echo_tb;
    import udp_echo_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    // Input bytes of all five tests
    localparam int TOTAL_BYTES  = 44 + 88 + 132 + 92 + 128;
    localparam int MAX_CYCLES   = 4 * TOTAL_BYTES + 2000;
    localparam ip_addr_t LOCAL_IP = 32'hC0A8_0A02;
    localparam ip_addr_t PEER_IP  = 32'hC0A8_0A63;
    // Requests go to the subnet broadcast address
    localparam ip_addr_t BCAST_IP = 32'hC0A8_0AFF;

    logic     clk;
    logic     reset;
    ip_addr_t local_ip;
    byte_t    in_data;
    logic     in_valid;
    logic     in_ready;
    logic     in_last;
    logic     in_user;
    byte_t    out_data;
    logic     out_valid;
    logic     out_ready;
    logic     out_last;
    logic     out_user;

    // Stream entries are {user, last, data}
    logic [9:0]  in_pkt[$];
    logic [9:0]  exp_q[$];
    logic [9:0]  out_q[$];
    byte_t       pay_q[$];
    logic [31:0] gen_state;
    logic        rand_ready;
    int          last_cnt = 0;
    int          cycle_cnt = 0;
    int          in_stalls = 0;
    int          err_cnt = 0;
    int          test_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       cur_test = "reset";

    udp_echo_top i_udp_echo_top (
        .clk       (clk),
        .reset     (reset),
        .local_ip  (local_ip),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .in_user   (in_user),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last),
        .out_user  (out_user)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s] %s: expected %0h, actual %0h", cur_test, what,
                     expected, actual);
            err_cnt = err_cnt + 1;
            test_errs = test_errs + 1;
        end
    endtask

    // Complement of the folded sum of the ten header words
    function automatic logic [15:0] ip_header_checksum(input logic [159:0] ip_hdr);
        logic [31:0] acc;
        acc = 32'd0;
        for (int i = 0; i < 10; i++) begin
            acc = acc + {16'd0, ip_hdr[159 - 16*i -: 16]};
        end
        while (acc[31:16] != 16'd0) begin
            acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        end
        return ~acc[15:0];
    endfunction

    task automatic build_packet(input udp_port_t src_port, input udp_port_t dst_port,
                                input byte_t ver_ihl, input byte_t proto,
                                input int pay_len, input logic user);
        logic [223:0] hdr;
        hdr = {ver_ihl, 8'h00, 16'(pay_len + 28), 32'h1234_0000, 8'd32, proto, 16'h0,
               PEER_IP, BCAST_IP, src_port, dst_port, 16'(pay_len + 8), 16'h0};
        in_pkt.delete();
        pay_q.delete();
        for (int i = 0; i < 28; i++) begin
            in_pkt.push_back({2'b00, hdr[223 - 8*i -: 8]});
        end
        for (int i = 0; i < pay_len; i++) begin
            gen_state = xorshift32(gen_state);
            pay_q.push_back(gen_state[7:0]);
            in_pkt.push_back({(i == pay_len - 1) && user, i == pay_len - 1, gen_state[7:0]});
        end
    endtask

    // Reply to the packet held in pay_q
    function automatic void add_expected_reply(input udp_port_t peer_port,
                                               input udp_port_t svc_port, input logic user);
        logic [159:0] ip_hdr;
        logic [223:0] rep;
        ip_hdr = {8'h45, 8'h00, 16'(pay_q.size() + 28), 32'h0, 8'd64, 8'd17, 16'h0,
                  LOCAL_IP, PEER_IP};
        ip_hdr[79:64] = ip_header_checksum(ip_hdr);
        rep = {ip_hdr, svc_port, peer_port, 16'(pay_q.size() + 8), 16'h0};
        for (int i = 0; i < 28; i++) begin
            exp_q.push_back({2'b00, rep[223 - 8*i -: 8]});
        end
        for (int i = 0; i < pay_q.size(); i++) begin
            logic last;
            last = (i == pay_q.size() - 1);
            exp_q.push_back({user && last, last, pay_q[i]});
        end
    endfunction

    task automatic send_packet(input logic gaps);
        logic fire;
        in_stalls = 0;
        foreach (in_pkt[i]) begin
            if (gaps) begin
                gen_state = xorshift32(gen_state);
                if (gen_state[1:0] == 2'd0) begin
                    in_valid = 1'b0;
                    repeat (1 + int'(gen_state[3:2])) @(posedge clk);
                    #1;
                end
            end
            in_data  = in_pkt[i][7:0];
            in_last  = in_pkt[i][8];
            in_user  = in_pkt[i][9];
            in_valid = 1'b1;
            fire = 1'b0;
            while (!fire) begin
                @(negedge clk);
                fire = in_ready;
                if (!fire) begin
                    in_stalls = in_stalls + 1;
                end
                @(posedge clk);
                #1;
            end
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_user  = 1'b0;
    endtask

    task automatic wait_replies(input int n);
        while (last_cnt < n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errs = 0;
        last_cnt = 0;
        out_q.delete();
        exp_q.delete();
    endtask

    task automatic finish_test();
        check_value("reply bytes", 32'(exp_q.size()), 32'(out_q.size()));
        foreach (exp_q[i]) begin
            if (i < out_q.size()) begin
                check_value($sformatf("byte %0d {user,last,data}", i), 32'(exp_q[i]),
                            32'(out_q[i]));
            end
        end
        tests_run = tests_run + 1;
        if (test_errs == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_failed = tests_failed + 1;
            $display("%s: %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic check_single_echo();
        start_test("echo");
        build_packet(16'd5000, 16'd7, 8'h45, 8'd17, 16, 1'b0);
        add_expected_reply(16'd5000, 16'd7, 1'b0);
        send_packet(1'b0);
        wait_replies(1);
        finish_test();
    endtask

    task automatic drop_wrong_port();
        start_test("port_filter");
        build_packet(16'd5001, 16'd8, 8'h45, 8'd17, 16, 1'b0);
        send_packet(1'b0);
        check_value("bytes after port 8", 32'd0, 32'(out_q.size()));
        build_packet(16'd5002, 16'd7, 8'h45, 8'd17, 16, 1'b0);
        add_expected_reply(16'd5002, 16'd7, 1'b0);
        send_packet(1'b0);
        wait_replies(1);
        finish_test();
    endtask

    task automatic drop_bad_header();
        start_test("protocol_filter");
        build_packet(16'd5003, 16'd7, 8'h45, 8'd6, 16, 1'b0);
        send_packet(1'b0);
        check_value("input stalls on TCP", 32'd0, 32'(in_stalls));
        check_value("bytes after TCP", 32'd0, 32'(out_q.size()));
        build_packet(16'd5004, 16'd7, 8'h46, 8'd17, 16, 1'b0);
        send_packet(1'b0);
        check_value("input stalls on IHL 6", 32'd0, 32'(in_stalls));
        check_value("bytes after IHL 6", 32'd0, 32'(out_q.size()));
        build_packet(16'd5005, 16'd7, 8'h45, 8'd17, 16, 1'b0);
        add_expected_reply(16'd5005, 16'd7, 1'b0);
        send_packet(1'b0);
        wait_replies(1);
        finish_test();
    endtask

    task automatic stress_backpressure();
        start_test("backpressure");
        rand_ready = 1'b1;
        build_packet(16'd6000, 16'd7, 8'h45, 8'd17, 64, 1'b0);
        add_expected_reply(16'd6000, 16'd7, 1'b0);
        send_packet(1'b1);
        wait_replies(1);
        rand_ready = 1'b0;
        finish_test();
    endtask

    task automatic send_back_to_back();
        start_test("back_to_back");
        build_packet(16'd7001, 16'd7, 8'h45, 8'd17, 1, 1'b0);
        add_expected_reply(16'd7001, 16'd7, 1'b0);
        send_packet(1'b0);
        build_packet(16'd7002, 16'd7, 8'h45, 8'd17, 3, 1'b1);
        add_expected_reply(16'd7002, 16'd7, 1'b1);
        send_packet(1'b0);
        build_packet(16'd7003, 16'd7, 8'h45, 8'd17, 40, 1'b0);
        add_expected_reply(16'd7003, 16'd7, 1'b0);
        send_packet(1'b0);
        wait_replies(3);
        finish_test();
    endtask

    // Sink ready is random only during the back-pressure test
    initial begin
        logic [31:0] rdy_state;
        rdy_state = 32'd9854;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (rand_ready) begin
                rdy_state = xorshift32(rdy_state);
                out_ready = rdy_state[0];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // Output monitor samples mid-cycle where everything is settled
    initial begin
        logic       stall_pend;
        logic [9:0] stall_val;
        stall_pend = 1'b0;
        stall_val = '0;
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (stall_pend) begin
                    check_value("held output {valid,user,last,data}", 32'({1'b1, stall_val}),
                                32'({out_valid, out_user, out_last, out_data}));
                end
                if (out_valid && out_ready) begin
                    out_q.push_back({out_user, out_last, out_data});
                    if (out_last) begin
                        last_cnt = last_cnt + 1;
                    end
                end
                stall_pend = out_valid && !out_ready;
                stall_val = {out_user, out_last, out_data};
            end
        end
    end

    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout in %s: run stopped after %0d cycles", cur_test, cycle_cnt);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        local_ip = LOCAL_IP;
        in_data = 8'h00;
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = 1'b0;
        rand_ready = 1'b0;
        gen_state = 32'd9854;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        check_single_echo();
        drop_wrong_port();
        drop_bad_header();
        stress_backpressure();
        send_back_to_back();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* udp_echo_top.f */
+incdir+include
verilog/udp_echo_pkg.sv
verilog/ip_udp_rx_parser.sv
verilog/udp_loopback.sv
verilog/ip_udp_tx_framer.sv
verilog/udp_echo_top.sv
verif/udp_echo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UDP echo simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f udp_echo_top.f --top-module udp_echo_tb -o udp_echo_sim

./obj_dir/udp_echo_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
exit 1
